/* Bender.yml */
package:
  name: row_filter

sources:
  - files:
      - rtl/row_filter_pkg.sv
      - rtl/line_buffer.sv
      - rtl/buffer_12_rows_ci.sv
      - rtl/vertical_box_filter.sv
      - rtl/row_filter_top.sv
  - target: test
    files:
      - dv/row_filter_checker.sv
      - dv/row_filter_tb.sv

/* dv/row_filter_checker.sv */
`default_nettype none

module row_filter_checker #(
  parameter int DEPTH = 17,
  parameter int HIST  = 8192
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire  [row_filter_pkg::PIX_W-1:0]     pixel_i,
  input  wire                                  done_i,
  input  wire  row_filter_pkg::filter_radius_e mode_i,
  input  wire  [row_filter_pkg::SUM_W-1:0]     dut_sum_i,
  input  wire                                  dut_done_i,
  output int                                   error_count_o,
  output int                                   check_count_o
);

  // entry j holds the inputs that the DUT samples at the j-th active rising edge
  logic [row_filter_pkg::PIX_W-1:0] pix_hist   [HIST];
  row_filter_pkg::filter_radius_e   mode_hist  [HIST];
  logic                             chain_hist [HIST];

  int                               n = 0;
  int                               last_pulse = -1;
  int                               errors = 0;
  int                               checks = 0;
  bit                               overflow_seen = 1'b0;
  logic [row_filter_pkg::SUM_W-1:0] exp_sum;
  logic                             exp_done;

  assign error_count_o = errors;
  assign check_count_o = checks;

  // anything entered before reset was released counts as zero
  function automatic logic [row_filter_pkg::PIX_W-1:0] pix_at(input int j);
    if (j < 0) begin
      return '0;
    end
    return pix_hist[j];
  endfunction

  function automatic logic chain_at(input int j);
    if (j < 0) begin
      return 1'b0;
    end
    return chain_hist[j];
  endfunction

  function automatic int radius_of(input row_filter_pkg::filter_radius_e mode);
    case (mode)
      row_filter_pkg::RADIUS_2: return 2;
      row_filter_pkg::RADIUS_4: return 4;
      default:                  return 6;
    endcase
  endfunction

  // expected outputs for a window whose rows and mode were sampled at entry j
  function automatic void ref_model(input int j, output logic [row_filter_pkg::SUM_W-1:0] sum,
                                    output logic done);
    int r;
    int acc;
    if (j < 0) begin
      sum  = '0;
      done = 1'b0;
      return;
    end
    r   = radius_of(mode_hist[j]);
    acc = 0;
    for (int k = row_filter_pkg::CENTER_ROW - r; k <= row_filter_pkg::CENTER_ROW + r; k++) begin
      acc += pix_at(j - k * DEPTH);
    end
    sum  = acc[row_filter_pkg::SUM_W-1:0];
    done = chain_at(j - 2 * r * DEPTH);
  endfunction

  // inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin
    if (rst_n && n < HIST) begin
      ref_model(n - 2, exp_sum, exp_done);
      checks++;
      if (dut_sum_i !== exp_sum) begin
        errors++;
        $display("MISMATCH sum_o expected 0x%03h actual 0x%03h at cycle %0d",
                 exp_sum, dut_sum_i, n);
      end
      if (dut_done_i !== exp_done) begin
        errors++;
        $display("MISMATCH done_o expected 0x%0h actual 0x%0h at cycle %0d",
                 exp_done, dut_done_i, n);
      end
      pix_hist[n]  = pixel_i;
      mode_hist[n] = mode_i;
      // the chain done stays high for DEPTH+1 cycles after the latest pulse
      if (done_i) begin
        last_pulse = n;
      end
      chain_hist[n] = (last_pulse >= 0) && (n - last_pulse <= DEPTH + 1);
      n++;
    end else if (rst_n && !overflow_seen) begin
      overflow_seen = 1'b1;
      errors++;
      $display("checker history is full after %0d cycles, later cycles were not checked", n);
    end
  end

endmodule

`default_nettype wire

/* dv/row_filter_tb.sv */
`default_nettype none

module row_filter_tb;

  localparam int DEPTH     = 17;
  localparam int FRAME_LEN = 250;

  logic                             clk;
  logic                             rst_n;
  logic [row_filter_pkg::PIX_W-1:0] pixel_i;
  logic                             done_i;
  row_filter_pkg::filter_radius_e   mode_i;
  logic [row_filter_pkg::SUM_W-1:0] sum_o;
  logic                             done_o;

  logic [31:0] rand_state;
  int          error_count;
  int          check_count;
  int          timeout_count;

  row_filter_top #(
    .DEPTH(DEPTH)
  ) uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .pixel_i(pixel_i),
    .done_i (done_i),
    .mode_i (mode_i),
    .sum_o  (sum_o),
    .done_o (done_o)
  );

  row_filter_checker #(
    .DEPTH(DEPTH)
  ) u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .pixel_i      (pixel_i),
    .done_i       (done_i),
    .mode_i       (mode_i),
    .dut_sum_i    (sum_o),
    .dut_done_i   (done_o),
    .error_count_o(error_count),
    .check_count_o(check_count)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic row_filter_pkg::filter_radius_e mode_for_step(input int step);
    case (step % 3)
      0:       return row_filter_pkg::RADIUS_2;
      1:       return row_filter_pkg::RADIUS_4;
      default: return row_filter_pkg::RADIUS_6;
    endcase
  endfunction

  // pulses is 0, 1 or 2; a second pulse lands ten pixels before the last one
  task automatic drive_frame(input row_filter_pkg::filter_radius_e mode, input bit all_ones,
                             input int pulses, input int switch_every);
    for (int p = 0; p < FRAME_LEN; p++) begin
      @(posedge clk);
      #5;
      rand_state = xorshift32(rand_state);
      pixel_i    = all_ones ? {row_filter_pkg::PIX_W{1'b1}} : rand_state[15:8];
      done_i     = (pulses > 0 && p == FRAME_LEN - 1) || (pulses > 1 && p == FRAME_LEN - 11);
      if (switch_every > 0) begin
        mode_i = mode_for_step(p / switch_every);
      end else begin
        mode_i = mode;
      end
    end
  endtask

  task automatic wait_done_level(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (done_o !== level && cycles < limit) begin
      @(posedge clk);
      #5;
      done_i     = 1'b0;
      rand_state = xorshift32(rand_state);
      pixel_i    = rand_state[15:8];
      cycles++;
    end
    if (done_o !== level) begin
      timeout_count++;
      $display("timeout: done_o did not go to %0b within %0d cycles", level, limit);
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    pixel_i       = '0;
    done_i        = 1'b0;
    mode_i        = row_filter_pkg::RADIUS_6;
    rand_state    = 32'h6ca4;
    timeout_count = 0;
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // each radius gets two frames so the first frame's strobe shows up under the same mode
    drive_frame(row_filter_pkg::RADIUS_6, 1'b0, 1, 0);
    drive_frame(row_filter_pkg::RADIUS_6, 1'b0, 1, 0);
    drive_frame(row_filter_pkg::RADIUS_2, 1'b0, 1, 0);
    drive_frame(row_filter_pkg::RADIUS_2, 1'b0, 1, 0);
    drive_frame(row_filter_pkg::RADIUS_4, 1'b0, 1, 0);
    drive_frame(row_filter_pkg::RADIUS_4, 1'b0, 1, 0);
    // mode changes every 23 pixels, off the row grid
    drive_frame(row_filter_pkg::RADIUS_6, 1'b0, 1, 23);
    drive_frame(row_filter_pkg::RADIUS_6, 1'b0, 2, 0);
    drive_frame(row_filter_pkg::RADIUS_6, 1'b1, 0, 0);
    drive_frame(row_filter_pkg::RADIUS_2, 1'b1, 0, 0);
    drive_frame(row_filter_pkg::RADIUS_4, 1'b1, 1, 0);

    wait_done_level(1'b1, 12 * DEPTH + 40);
    wait_done_level(1'b0, DEPTH + 10);
    repeat (4) @(posedge clk);
    #5;

    $display("checks: %0d  mismatches: %0d  timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
rtl/row_filter_pkg.sv
rtl/line_buffer.sv
rtl/buffer_12_rows_ci.sv
rtl/vertical_box_filter.sv
rtl/row_filter_top.sv
dv/row_filter_checker.sv
dv/row_filter_tb.sv

/* rtl/buffer_12_rows_ci.sv */
`default_nettype none

module buffer_12_rows_ci #(
  parameter int DEPTH = 17
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               done_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]  data_i,
  output logic [row_filter_pkg::PIX_W-1:0]  data0_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data1_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data2_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data3_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data4_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data5_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data6_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data7_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data8_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data9_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data10_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data11_o,
  output logic [row_filter_pkg::PIX_W-1:0]  data12_o,
  output logic                              done_r6_o,
  output logic                              done_r4_o,
  output logic                              done_r2_o
);

  localparam int NUM_BUFS = row_filter_pkg::NUM_ROWS - 1;

  logic [9:0] stretch_cnt;
  logic       stretch;

  // chain_data[k] is the input delayed by k rows, chain_data[0] is the input
  logic [row_filter_pkg::PIX_W-1:0] chain_data [row_filter_pkg::NUM_ROWS];
  logic                             chain_done [row_filter_pkg::NUM_ROWS];

  // keep done asserted for DEPTH+1 more cycles so the whole last row
  // carries the flag into the first buffer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stretch_cnt <= '0;
      stretch     <= 1'b0;
    end else if (done_i) begin
      // a new pulse restarts the stretch
      stretch_cnt <= '0;
      stretch     <= 1'b1;
    end else if (stretch && (stretch_cnt < DEPTH)) begin
      stretch_cnt <= stretch_cnt + 10'd1;
      stretch     <= 1'b1;
    end else begin
      stretch_cnt <= '0;
      stretch     <= 1'b0;
    end
  end

  assign chain_data[0] = data_i;
  assign chain_done[0] = done_i | stretch;

  for (genvar i = 0; i < NUM_BUFS; i++) begin : gen_line_buffers
    line_buffer #(
      .DEPTH(DEPTH)
    ) u_line_buffer (
      .clk   (clk),
      .rst_n (rst_n),
      .data_i(chain_data[i]),
      .done_i(chain_done[i]),
      .data_o(chain_data[i+1]),
      .done_o(chain_done[i+1])
    );
  end

  assign data0_o  = chain_data[0];
  assign data1_o  = chain_data[1];
  assign data2_o  = chain_data[2];
  assign data3_o  = chain_data[3];
  assign data4_o  = chain_data[4];
  assign data5_o  = chain_data[5];
  assign data6_o  = chain_data[6];
  assign data7_o  = chain_data[7];
  assign data8_o  = chain_data[8];
  assign data9_o  = chain_data[9];
  assign data10_o = chain_data[10];
  assign data11_o = chain_data[11];
  assign data12_o = chain_data[12];

  // taps after buffers 3, 7 and 11, i.e. 4, 8 and 12 rows down the chain
  assign done_r2_o = chain_done[4];
  assign done_r4_o = chain_done[8];
  assign done_r6_o = chain_done[12];

  // the counter stops at DEPTH, so the stretch ends exactly DEPTH+2 cycles
  // after the latest pulse and never runs past the row that is being flushed
  stretch_len_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(stretch) |-> $past(done_i, DEPTH + 2)
  );

endmodule

`default_nettype wire

/* rtl/line_buffer.sv */
`default_nettype none

module line_buffer #(
  parameter int DEPTH = 17
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire  [row_filter_pkg::PIX_W-1:0]  data_i,
  input  wire                               done_i,
  output logic [row_filter_pkg::PIX_W-1:0]  data_o,
  output logic                              done_o
);

  logic [row_filter_pkg::PIX_W-1:0] data_q [DEPTH];
  logic                             done_q [DEPTH];

  // pixel and done shift together so the flag stays aligned with its row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        data_q[i] <= '0;
        done_q[i] <= 1'b0;
      end
    end else begin
      data_q[0] <= data_i;
      done_q[0] <= done_i;
      for (int i = 1; i < DEPTH; i++) begin
        data_q[i] <= data_q[i-1];
        done_q[i] <= done_q[i-1];
      end
    end
  end

  // last stage holds the value entered DEPTH cycles ago
  assign data_o = data_q[DEPTH-1];
  assign done_o = done_q[DEPTH-1];

  // the done flag feeds the next row and finally the frame strobe, so an X
  // here would leak all the way to done_o of the top level
  done_known_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(done_o)
  );

endmodule

`default_nettype wire

/* rtl/row_filter_pkg.sv */
`default_nettype none

package row_filter_pkg;

  // pixel width of the incoming raster stream
  localparam int PIX_W = 8;

  // a full 13-row window of 8-bit pixels peaks at 3315, so 12 bits is enough
  localparam int SUM_W = 12;

  // rows available in the vertical column, row 0 being the live input
  localparam int NUM_ROWS = 13;

  // centre of the column, the window grows symmetrically around it
  localparam int CENTER_ROW = 6;

  // vertical window radius, giving windows of 5, 9 and 13 rows
  typedef enum logic [1:0] {
    RADIUS_2 = 2'd0,
    RADIUS_4 = 2'd1,
    RADIUS_6 = 2'd2
  } filter_radius_e;

endpackage

`default_nettype wire

/* rtl/row_filter_top.sv */
`default_nettype none

module row_filter_top #(
  parameter int DEPTH = 17
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire  [row_filter_pkg::PIX_W-1:0]     pixel_i,
  input  wire                                  done_i,
  input  wire  row_filter_pkg::filter_radius_e mode_i,
  output logic [row_filter_pkg::SUM_W-1:0]     sum_o,
  output logic                                 done_o
);

  logic [row_filter_pkg::PIX_W-1:0] data0, data1, data2, data3, data4;
  logic [row_filter_pkg::PIX_W-1:0] data5, data6, data7, data8;
  logic [row_filter_pkg::PIX_W-1:0] data9, data10, data11, data12;
  logic                             done_r2, done_r4, done_r6;

  // row k of the column is the pixel stream delayed by k*DEPTH cycles
  buffer_12_rows_ci #(
    .DEPTH(DEPTH)
  ) u_rows (
    .clk      (clk),
    .rst_n    (rst_n),
    .done_i   (done_i),
    .data_i   (pixel_i),
    .data0_o  (data0),
    .data1_o  (data1),
    .data2_o  (data2),
    .data3_o  (data3),
    .data4_o  (data4),
    .data5_o  (data5),
    .data6_o  (data6),
    .data7_o  (data7),
    .data8_o  (data8),
    .data9_o  (data9),
    .data10_o (data10),
    .data11_o (data11),
    .data12_o (data12),
    .done_r6_o(done_r6),
    .done_r4_o(done_r4),
    .done_r2_o(done_r2)
  );

  vertical_box_filter u_filter (
    .clk      (clk),
    .rst_n    (rst_n),
    .row0_i   (data0),
    .row1_i   (data1),
    .row2_i   (data2),
    .row3_i   (data3),
    .row4_i   (data4),
    .row5_i   (data5),
    .row6_i   (data6),
    .row7_i   (data7),
    .row8_i   (data8),
    .row9_i   (data9),
    .row10_i  (data10),
    .row11_i  (data11),
    .row12_i  (data12),
    .mode_i   (mode_i),
    .done_r2_i(done_r2),
    .done_r4_i(done_r4),
    .done_r6_i(done_r6),
    .sum_o    (sum_o),
    .done_o   (done_o)
  );

endmodule

`default_nettype wire

/* rtl/vertical_box_filter.sv */
`default_nettype none

module vertical_box_filter (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row0_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row1_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row2_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row3_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row4_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row5_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row6_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row7_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row8_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row9_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row10_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row11_i,
  input  wire  [row_filter_pkg::PIX_W-1:0]     row12_i,
  input  wire  row_filter_pkg::filter_radius_e mode_i,
  input  wire                                  done_r2_i,
  input  wire                                  done_r4_i,
  input  wire                                  done_r6_i,
  output logic [row_filter_pkg::SUM_W-1:0]     sum_o,
  output logic                                 done_o
);

  localparam int CTR = row_filter_pkg::CENTER_ROW;

  logic [row_filter_pkg::PIX_W-1:0] rows    [row_filter_pkg::NUM_ROWS];
  logic [row_filter_pkg::SUM_W-1:0] row_ext [row_filter_pkg::NUM_ROWS];

  logic [row_filter_pkg::SUM_W-1:0] inner_d, mid_d, outer_d;
  logic [row_filter_pkg::SUM_W-1:0] inner_q, mid_q, outer_q;
  row_filter_pkg::filter_radius_e   mode_q;
  logic                             done_r2_q, done_r4_q, done_r6_q;

  logic [row_filter_pkg::SUM_W-1:0] sum_d;
  logic                             done_d;

  assign rows[0]  = row0_i;
  assign rows[1]  = row1_i;
  assign rows[2]  = row2_i;
  assign rows[3]  = row3_i;
  assign rows[4]  = row4_i;
  assign rows[5]  = row5_i;
  assign rows[6]  = row6_i;
  assign rows[7]  = row7_i;
  assign rows[8]  = row8_i;
  assign rows[9]  = row9_i;
  assign rows[10] = row10_i;
  assign rows[11] = row11_i;
  assign rows[12] = row12_i;

  for (genvar k = 0; k < row_filter_pkg::NUM_ROWS; k++) begin : gen_row_ext
    assign row_ext[k] = {{(row_filter_pkg::SUM_W - row_filter_pkg::PIX_W){1'b0}}, rows[k]};
  end

  // stage 1 splits the window into the radius-2 core and two rings
  assign inner_d = row_ext[CTR-2] + row_ext[CTR-1] + row_ext[CTR]
                 + row_ext[CTR+1] + row_ext[CTR+2];
  assign mid_d   = row_ext[CTR-4] + row_ext[CTR-3] + row_ext[CTR+3] + row_ext[CTR+4];
  assign outer_d = row_ext[CTR-6] + row_ext[CTR-5] + row_ext[CTR+5] + row_ext[CTR+6];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inner_q   <= '0;
      mid_q     <= '0;
      outer_q   <= '0;
      mode_q    <= row_filter_pkg::RADIUS_2;
      done_r2_q <= 1'b0;
      done_r4_q <= 1'b0;
      done_r6_q <= 1'b0;
    end else begin
      inner_q   <= inner_d;
      mid_q     <= mid_d;
      outer_q   <= outer_d;
      mode_q    <= mode_i;
      done_r2_q <= done_r2_i;
      done_r4_q <= done_r4_i;
      done_r6_q <= done_r6_i;
    end
  end

  // stage 2 adds the rings that the mode of the previous cycle asks for
  always_comb begin
    case (mode_q)
      row_filter_pkg::RADIUS_2: begin
        sum_d  = inner_q;
        done_d = done_r2_q;
      end
      row_filter_pkg::RADIUS_4: begin
        sum_d  = inner_q + mid_q;
        done_d = done_r4_q;
      end
      row_filter_pkg::RADIUS_6: begin
        sum_d  = inner_q + mid_q + outer_q;
        done_d = done_r6_q;
      end
      default: begin
        sum_d  = '0;
        done_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_o  <= '0;
      done_o <= 1'b0;
    end else begin
      sum_o  <= sum_d;
      done_o <= done_d;
    end
  end

  // an unused encoding would silently drop both the sum and the strobe
  mode_legal_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    mode_i inside {row_filter_pkg::RADIUS_2, row_filter_pkg::RADIUS_4,
                   row_filter_pkg::RADIUS_6}
  );

endmodule

`default_nettype wire
